/* Bender.yml */
package:
  name: decode_stage

sources:
  - include_dirs:
      - include
    files:
      - rtl/decode_pkg.sv
      - rtl/instrDecoder.sv
      - rtl/regFileScoreboard.sv
      - rtl/issueStage.sv
      - rtl/decodeStage.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tbClockGen.sv
      - dv/decodeStage_asserts.sv
      - dv/decodeStage_tb.sv

/* dv/decodeStage_asserts.sv */
`timescale 1ns/1ps

module decodeStage_asserts
(
  input logic                I_CLOCK,
  input logic                rstN,
  input logic                inValid,
  input logic                inReady,
  input logic                outValid,
  input logic                outReady,
  input decodePkg::pcT       outPc,
  input decodePkg::opcodeT   outOpcode,
  input decodePkg::regDataT  outSrc1,
  input decodePkg::regDataT  outSrc2,
  input decodePkg::regDataT  outImm,
  input decodePkg::regIdxT   outDestIdx,
  input logic                outWritesDest,
  input decodePkg::regDataT  outDestValue,
  input logic                claimEnable,
  input decodePkg::regIdxT   claimIdx
);

  int errorCount = 0;  // read by the testbench top

  ////////////////////////////////////////
  // reset and handshake rules
  ////////////////////////////////////////
  // output register empty right after a reset edge
  assert property (@(posedge I_CLOCK) !rstN |=> !outValid)
  else
  begin
    $error("outValid high in the cycle after reset");
    errorCount++;
  end

  // stalled output holds every field
  assert property (@(posedge I_CLOCK) disable iff (!rstN)
    (outValid && !outReady) |=> (outValid && $stable(outPc) && $stable(outOpcode)
      && $stable(outSrc1) && $stable(outSrc2) && $stable(outImm)
      && $stable(outDestIdx) && $stable(outWritesDest) && $stable(outDestValue)))
  else
  begin
    $error("decode outputs changed while execute held outReady low");
    errorCount++;
  end

  // claim only on a real accept, claimed register shows up as dest next cycle
  assert property (@(posedge I_CLOCK) disable iff (!rstN)
    claimEnable |-> (inValid && inReady)
      ##1 (outValid && outWritesDest && (outDestIdx == $past(claimIdx))))
  else
  begin
    $error("register claimed without a matching accepted instruction");
    errorCount++;
  end

endmodule

bind decodeStage decodeStage_asserts asserts (.*);

/* dv/decodeStage_tb.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module decodeStage_tb;

  localparam int NUM_ROWS    = 22;
  localparam int CYCLE_LIMIT = NUM_ROWS * 40 + 20;

  logic                I_CLOCK;
  logic                rstN;
  logic                inValid;
  decodePkg::instrT    inInstr;
  decodePkg::pcT       inPc;
  logic                inReady;
  logic                outValid;
  logic                outReady;
  decodePkg::pcT       outPc;
  decodePkg::opcodeT   outOpcode;
  decodePkg::regDataT  outSrc1;
  decodePkg::regDataT  outSrc2;
  decodePkg::regDataT  outImm;
  decodePkg::regIdxT   outDestIdx;
  logic                outWritesDest;
  decodePkg::regDataT  outDestValue;
  logic                wbEnable;
  decodePkg::regIdxT   wbIdx;
  decodePkg::regDataT  wbData;

  // stimulus table, one entry per instruction
  int                  rowWbCount [NUM_ROWS];
  decodePkg::regIdxT   rowWbIdx   [NUM_ROWS][2];
  decodePkg::regDataT  rowWbData  [NUM_ROWS][2];
  decodePkg::instrT    rowInstr   [NUM_ROWS];
  decodePkg::pcT       rowPc      [NUM_ROWS];
  int                  rowStalls  [NUM_ROWS];   // -1 picks a random length
  logic                rowReady   [NUM_ROWS];   // inReady before writebacks
  int                  rowCount = 0;

  // golden model state
  decodePkg::regDataT  mRegs [`NUM_REGS];
  decodePkg::regMaskT  mValid;
  decodePkg::condCodeT mCc;

  // expected outputs for the current row
  decodePkg::pcT       ePc;
  decodePkg::opcodeT   eOpcode;
  decodePkg::regDataT  eSrc1;
  decodePkg::regDataT  eSrc2;
  decodePkg::regDataT  eImm;
  decodePkg::regIdxT   eDestIdx;
  logic                eWrites;
  decodePkg::regDataT  eDestValue;
  logic                chkSrc1;
  logic                chkSrc2;
  logic                chkDestValue;
  logic                mHazard;

  int                  cycleCount    = 0;
  int                  transferCount = 0;

  tbClockGen clockGen
  (
    .I_CLOCK (I_CLOCK),
    .rstN    (rstN)
  );

  decodeStage UUT
  (
    .I_CLOCK       (I_CLOCK),
    .rstN          (rstN),
    .inValid       (inValid),
    .inInstr       (inInstr),
    .inPc          (inPc),
    .inReady       (inReady),
    .outValid      (outValid),
    .outReady      (outReady),
    .outPc         (outPc),
    .outOpcode     (outOpcode),
    .outSrc1       (outSrc1),
    .outSrc2       (outSrc2),
    .outImm        (outImm),
    .outDestIdx    (outDestIdx),
    .outWritesDest (outWritesDest),
    .outDestValue  (outDestValue),
    .wbEnable      (wbEnable),
    .wbIdx         (wbIdx),
    .wbData        (wbData)
  );

  ////////////////////////////////////////
  // watchdog and execute-side monitor
  ////////////////////////////////////////
  always @(posedge I_CLOCK)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT)
    begin
      $display("Timeout: no finish after %0d clock cycles, the DUT seems stuck", CYCLE_LIMIT);
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  always @(posedge I_CLOCK)
  begin
    if (UUT.asserts.errorCount != 0)
    begin
      $display("A bound assertion on decodeStage fired");
      $display("Testbench failed");
      $fatal(1, "assertion");
    end
  end

  always @(posedge I_CLOCK)
  begin
    if (rstN && outValid && outReady)
      transferCount <= transferCount + 1;  // one handoff to execute
  end

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    assert (got === expected)
    else
    begin
      $display("CHECK FAILED: %s = 0x%h, expected 0x%h", name, got, expected);
      $display("Testbench failed");
      $fatal(1, "check");
    end
  endtask

  task automatic nextDrive();
    @(posedge I_CLOCK);
    #2;
  endtask

  ////////////////////////////////////////
  // golden model
  ////////////////////////////////////////
  task automatic modelWrite(input decodePkg::regIdxT idx, input decodePkg::regDataT data);
    mRegs[idx]  = data;
    mValid[idx] = 1'b1;
    if (data[15])
      mCc = `CC_N;         // sign bit set
    else if (data == '0)
      mCc = `CC_Z;
    else
      mCc = `CC_P;
  endtask

  task automatic predict(input decodePkg::instrT instr, input decodePkg::pcT pc);
    decodePkg::opcodeT op;
    logic [3:0]        d;
    logic [3:0]        s1;
    logic [3:0]        s2;
    op           = instr[31:24];
    d            = instr[23:20];
    s1           = instr[19:16];
    s2           = instr[11:8];
    ePc          = pc;
    eOpcode      = op;
    eImm         = instr[15:0];  // already a full word
    eSrc1        = mRegs[s1];
    eSrc2        = mRegs[s2];
    eWrites      = 1'b0;
    eDestIdx     = d;
    eDestValue   = '0;
    chkSrc1      = 1'b0;
    chkSrc2      = 1'b0;
    chkDestValue = 1'b0;
    mHazard      = 1'b0;
    case (op)
      `OP_ADD, `OP_AND:
      begin
        chkSrc1 = 1'b1;
        chkSrc2 = 1'b1;
        eWrites = 1'b1;
        mHazard = !mValid[s1] || !mValid[s2];
      end
      `OP_ADDI, `OP_ANDI, `OP_LDW:
      begin
        chkSrc1 = 1'b1;
        eWrites = 1'b1;
        mHazard = !mValid[s1];
      end
      `OP_MOV:
      begin
        chkSrc2  = 1'b1;
        eWrites  = 1'b1;
        eDestIdx = s1;      // moves name dest in 19:16
        mHazard  = !mValid[s2];
      end
      `OP_MOVI:
      begin
        eWrites  = 1'b1;
        eDestIdx = s1;
      end
      `OP_STW:
      begin
        chkSrc1      = 1'b1;  // base
        chkDestValue = 1'b1;
        eDestValue   = mRegs[d];
        mHazard      = !mValid[s1] || !mValid[d];
      end
      `OP_JMP:
      begin
        chkDestValue = 1'b1;
        eDestValue   = mRegs[s1];
        mHazard      = !mValid[s1];
      end
      `OP_JSR:
      begin
        eWrites      = 1'b1;
        eDestIdx     = `LINK_REG;
        eImm         = instr[15:0] << 2;
        chkDestValue = 1'b1;
        eDestValue   = pc;
      end
      `OP_JSRR:
      begin
        chkSrc1      = 1'b1;
        eWrites      = 1'b1;
        eDestIdx     = `LINK_REG;
        chkDestValue = 1'b1;
        eDestValue   = pc;
        mHazard      = !mValid[s1];
      end
      default:
      begin
        if ((op[7:3] == `OP_BR_PREFIX) && (op[2:0] != 3'b000))
        begin
          mHazard = (mValid != '1);  // any claim blocks a branch
          eImm    = ((mCc & op[2:0]) != 3'b000) ? (instr[15:0] << 2) : '0;
        end
      end
    endcase
  endtask

  task automatic checkOutputs();
    checkValue("outValid", outValid, 1'b1);
    checkValue("outPc", outPc, ePc);
    checkValue("outOpcode", outOpcode, eOpcode);
    if (chkSrc1)
      checkValue("outSrc1", outSrc1, eSrc1);
    if (chkSrc2)
      checkValue("outSrc2", outSrc2, eSrc2);
    checkValue("outImm", outImm, eImm);
    checkValue("outWritesDest", outWritesDest, eWrites);
    if (eWrites)
      checkValue("outDestIdx", outDestIdx, eDestIdx);
    if (chkDestValue)
      checkValue("outDestValue", outDestValue, eDestValue);
  endtask

  ////////////////////////////////////////
  // table
  ////////////////////////////////////////
  function automatic decodePkg::instrT encode(input decodePkg::opcodeT op, input logic [3:0] d,
                                              input logic [3:0] s1, input logic [15:0] low);
    return {op, d, s1, low};
  endfunction

  task automatic addRow(input int wbCount, input logic [3:0] idx0, input logic [15:0] data0,
                        input logic [3:0] idx1, input logic [15:0] data1,
                        input decodePkg::instrT instr, input int stalls, input logic ready);
    rowWbCount[rowCount]   = wbCount;
    rowWbIdx[rowCount][0]  = idx0;
    rowWbData[rowCount][0] = data0;
    rowWbIdx[rowCount][1]  = idx1;
    rowWbData[rowCount][1] = data1;
    rowInstr[rowCount]     = instr;
    rowPc[rowCount]        = 16'h0100 + 16'(rowCount * 4);
    rowStalls[rowCount]    = stalls;
    rowReady[rowCount]     = ready;
    rowCount++;
  endtask

  task automatic loadTable();
    // 16'h0200 in the low half selects R2 as src2
    addRow(0, 0, 16'h0000, 0, 0, encode({`OP_BR_PREFIX, 3'b111}, 0, 0, 16'h0005), 0, 1);
    addRow(2, 1, 16'h1234, 2, 16'h00F0, encode(`OP_ADD, 4, 1, 16'h0200), 0, 1);
    addRow(1, 4, 16'h1324, 0, 0, encode(`OP_AND, 6, 1, 16'h0200), 0, 1);
    addRow(1, 6, 16'h0030, 0, 0, encode(`OP_ADDI, 8, 1, 16'hFFFD), 0, 1);
    addRow(1, 8, 16'h1231, 0, 0, encode(`OP_ANDI, 9, 2, 16'h8F0F), 1, 1);
    addRow(1, 9, 16'h0000, 0, 0, encode(`OP_MOV, 0, 10, 16'h0200), 0, 1);
    addRow(1, 10, 16'h00F0, 0, 0, encode(`OP_MOVI, 0, 11, 16'h7FFF), 0, 1);
    addRow(1, 11, 16'h7FFF, 0, 0, encode(`OP_LDW, 12, 1, 16'h0010), 0, 1);
    addRow(1, 12, 16'hABCD, 0, 0, encode(`OP_STW, 2, 1, 16'h0008), 3, 1);
    addRow(0, 0, 16'h0000, 0, 0, encode(`OP_ADDI, 3, 1, 16'h0001), 0, 1);
    addRow(1, 3, 16'h1235, 0, 0, encode(`OP_ADD, 13, 3, 16'h0200), 0, 0);   // R3 in flight
    addRow(1, 13, 16'h8000, 0, 0, encode({`OP_BR_PREFIX, 3'b100}, 0, 0, 16'h0010), 0, 0);
    addRow(0, 0, 16'h0000, 0, 0, encode({`OP_BR_PREFIX, 3'b010}, 0, 0, 16'h0010), -1, 1);
    addRow(1, 14, 16'h0000, 0, 0, encode({`OP_BR_PREFIX, 3'b010}, 0, 0, 16'hFFFE), 0, 1);
    addRow(0, 0, 16'h0000, 0, 0, encode({`OP_BR_PREFIX, 3'b101}, 0, 0, 16'h0007), 0, 1);
    addRow(1, 15, 16'h0042, 0, 0, encode({`OP_BR_PREFIX, 3'b001}, 0, 0, 16'h0003), 0, 1);
    addRow(0, 0, 16'h0000, 0, 0, encode({`OP_BR_PREFIX, 3'b110}, 0, 0, 16'h0003), 0, 1);
    addRow(0, 0, 16'h0000, 0, 0, encode(`OP_JSR, 0, 0, 16'h0020), -1, 1);
    addRow(1, 7, 16'h0148, 0, 0, encode(`OP_JMP, 0, 7, 16'h0000), 0, 0);    // link pending
    addRow(0, 0, 16'h0000, 0, 0, encode(`OP_JSRR, 0, 1, 16'h0000), 2, 1);
    addRow(1, 7, 16'h0154, 0, 0, encode(`OP_ADD, 5, 7, 16'h0200), -1, 0);
    addRow(1, 5, 16'h0011, 0, 0, encode({`OP_BR_PREFIX, 3'b111}, 0, 0, 16'h0001), 0, 0);
  endtask

  ////////////////////////////////////////
  // one row: present, write back, accept, drain
  ////////////////////////////////////////
  task automatic runRow(input int r);
    int stalls;
    int sentBefore;
    nextDrive();
    inInstr = rowInstr[r];
    inPc    = rowPc[r];
    inValid = 1'b0;
    #1;
    checkValue("inReady", inReady, rowReady[r]);  // before any writeback
    if (!rowReady[r])
    begin
      inValid = 1'b1;
      repeat (2)
      begin
        @(posedge I_CLOCK);
        #3;
        checkValue("inReady", inReady, 1'b0);    // still blocked
        checkValue("outValid", outValid, 1'b0);
      end
    end
    for (int k = 0; k < rowWbCount[r]; k++)
    begin
      nextDrive();
      wbEnable = 1'b1;
      wbIdx    = rowWbIdx[r][k];
      wbData   = rowWbData[r][k];
      modelWrite(rowWbIdx[r][k], rowWbData[r][k]);
      if (k == rowWbCount[r] - 1)
        inValid = 1'b1;  // last write shares the accept cycle, bypass path
    end
    if (rowWbCount[r] == 0)
    begin
      nextDrive();
      inValid = 1'b1;
    end
    predict(rowInstr[r], rowPc[r]);
    #1;
    checkValue("inReady", inReady, !mHazard);
    while (!inReady)
    begin
      @(posedge I_CLOCK);
      #2;
      wbEnable = 1'b0;
      #1;
    end
    @(posedge I_CLOCK);  // accept edge
    #2;
    wbEnable = 1'b0;
    inValid  = 1'b0;
    if (eWrites)
      mValid[eDestIdx] = 1'b0;  // claimed on accept
    #1;
    checkOutputs();
    stalls = (rowStalls[r] < 0) ? int'($urandom % 4) + 1 : rowStalls[r];
    repeat (stalls)
    begin
      @(posedge I_CLOCK);
      #3;
      checkOutputs();
      checkValue("inReady", inReady, 1'b0);
    end
    nextDrive();
    outReady   = 1'b1;
    sentBefore = transferCount;
    #1;
    checkOutputs();
    nextDrive();
    outReady = 1'b0;
    #1;
    checkValue("transferCount", transferCount, sentBefore + 1);  // exactly one handoff
    checkValue("outValid", outValid, 1'b0);
  endtask

  initial
  begin
    void'($urandom(32'h9ae6_8dc3));
    inValid  = 1'b0;
    inInstr  = '0;
    inPc     = '0;
    outReady = 1'b0;
    wbEnable = 1'b0;
    wbIdx    = '0;
    wbData   = '0;
    for (int i = 0; i < `NUM_REGS; i++)
    begin
      mRegs[i] = '0;
    end
    mValid = '1;
    mCc    = '0;
    loadTable();

    wait (rstN === 1'b1);
    #1;
    checkValue("outValid", outValid, 1'b0);  // empty after reset

    for (int r = 0; r < rowCount; r++)
    begin
      runRow(r);
    end

    nextDrive();
    #1;
    checkValue("transferCount", transferCount, NUM_ROWS);
    if (UUT.asserts.errorCount == 0)
    begin
      $display("Testbench passed");
      $finish;
    end
    else
    begin
      $display("Testbench failed");
      $fatal(1, "assertion errors");
    end
  end

endmodule

/* dv/tbClockGen.sv */
`timescale 1ns/1ps

module tbClockGen
#(
  parameter real PERIOD       = 20.0,  // ns
  parameter int  RESET_CYCLES = 5
)
(
  output logic I_CLOCK,
  output logic rstN
);

  initial
  begin
    I_CLOCK = 1'b0;
    forever #(PERIOD / 2.0) I_CLOCK = ~I_CLOCK;
  end

  // release lands just after an edge, same as the other inputs
  initial
  begin
    rstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge I_CLOCK);
    #2;
    rstN = 1'b1;
  end

endmodule

/* include/decode_defs.svh */
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////
`define DATA_WIDTH    16  // register word and immediate
`define INSTR_WIDTH   32
`define PC_WIDTH      16
`define OPCODE_WIDTH  8   // instr[31:24]
`define CC_WIDTH      3   // n z p

// register file shape
`define NUM_REGS      16
`define REG_IDX_WIDTH 4
`define LINK_REG      7   // return address for JSR / JSRR

////////////////////////////////////////
// opcodes
////////////////////////////////////////
// alu
`define OP_ADD        8'h00
`define OP_ADDI       8'h01
`define OP_AND        8'h02
`define OP_ANDI       8'h03

// moves and memory
`define OP_MOV        8'h04
`define OP_MOVI       8'h05
`define OP_LDW        8'h06
`define OP_STW        8'h07

// jumps
`define OP_JMP        8'h10
`define OP_JSR        8'h11
`define OP_JSRR       8'h12

// branch family, low three bits are the n z p mask
`define OP_BR_PREFIX  5'b00101

// condition code encodings
`define CC_N          3'b100
`define CC_Z          3'b010
`define CC_P          3'b001

`endif

/* rtl/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage
(
  input  logic               I_CLOCK,
  input  logic               rstN,

  // fetch
  input  logic               inValid,
  input  decodePkg::instrT   inInstr,
  input  decodePkg::pcT      inPc,
  output logic               inReady,

  // execute
  output logic               outValid,
  input  logic               outReady,
  output decodePkg::pcT      outPc,
  output decodePkg::opcodeT  outOpcode,
  output decodePkg::regDataT outSrc1,
  output decodePkg::regDataT outSrc2,
  output decodePkg::regDataT outImm,
  output decodePkg::regIdxT  outDestIdx,
  output logic               outWritesDest,
  output decodePkg::regDataT outDestValue,

  // writeback
  input  logic               wbEnable,
  input  decodePkg::regIdxT  wbIdx,
  input  decodePkg::regDataT wbData
);

  ////////////////////////////////////////
  // decoder to issue / register file
  ////////////////////////////////////////
  decodePkg::opcodeT   opcode;
  decodePkg::regIdxT   src1Idx;
  decodePkg::regIdxT   src2Idx;
  decodePkg::regIdxT   destIdx;
  logic                useSrc1;
  logic                useSrc2;
  logic                writesDest;
  logic                isBranch;
  decodePkg::condCodeT branchMask;
  logic                isLink;
  decodePkg::regDataT  imm;

  // register file to issue
  decodePkg::regDataT  src1Data;
  decodePkg::regDataT  src2Data;
  logic                src1Ready;
  logic                src2Ready;
  logic                allReady;
  decodePkg::condCodeT condCode;

  // issue back to scoreboard
  logic                claimEnable;
  decodePkg::regIdxT   claimIdx;

  instrDecoder decoder
  (
    .instr      (inInstr),
    .opcode     (opcode),
    .src1Idx    (src1Idx),
    .src2Idx    (src2Idx),
    .destIdx    (destIdx),
    .useSrc1    (useSrc1),
    .useSrc2    (useSrc2),
    .writesDest (writesDest),
    .isBranch   (isBranch),
    .branchMask (branchMask),
    .isLink     (isLink),
    .imm        (imm)
  );

  regFileScoreboard regFile
  (
    .I_CLOCK     (I_CLOCK),
    .rstN        (rstN),
    .wbEnable    (wbEnable),
    .wbIdx       (wbIdx),
    .wbData      (wbData),
    .src1Idx     (src1Idx),
    .src2Idx     (src2Idx),
    .claimEnable (claimEnable),
    .claimIdx    (claimIdx),
    .src1Data    (src1Data),
    .src2Data    (src2Data),
    .src1Ready   (src1Ready),
    .src2Ready   (src2Ready),
    .allReady    (allReady),
    .condCode    (condCode)
  );

  issueStage issue
  (
    .I_CLOCK       (I_CLOCK),
    .rstN          (rstN),
    .inValid       (inValid),
    .inPc          (inPc),
    .inReady       (inReady),
    .opcode        (opcode),
    .src1Idx       (src1Idx),
    .src2Idx       (src2Idx),
    .destIdx       (destIdx),
    .useSrc1       (useSrc1),
    .useSrc2       (useSrc2),
    .writesDest    (writesDest),
    .isBranch      (isBranch),
    .branchMask    (branchMask),
    .isLink        (isLink),
    .imm           (imm),
    .src1Data      (src1Data),
    .src2Data      (src2Data),
    .src1Ready     (src1Ready),
    .src2Ready     (src2Ready),
    .allReady      (allReady),
    .condCode      (condCode),
    .claimEnable   (claimEnable),
    .claimIdx      (claimIdx),
    .outValid      (outValid),
    .outReady      (outReady),
    .outPc         (outPc),
    .outOpcode     (outOpcode),
    .outSrc1       (outSrc1),
    .outSrc2       (outSrc2),
    .outImm        (outImm),
    .outDestIdx    (outDestIdx),
    .outWritesDest (outWritesDest),
    .outDestValue  (outDestValue)
  );

endmodule

/* rtl/decode_pkg.sv */
`include "decode_defs.svh"

package decodePkg;

  ////////////////////////////////////////
  // datapath words
  ////////////////////////////////////////
  typedef logic [`DATA_WIDTH-1:0]    regDataT;  // one register value
  typedef logic [`INSTR_WIDTH-1:0]   instrT;    // raw instruction from fetch
  typedef logic [`PC_WIDTH-1:0]      pcT;

  // instruction fields
  typedef logic [`REG_IDX_WIDTH-1:0] regIdxT;   // register number
  typedef logic [`OPCODE_WIDTH-1:0]  opcodeT;

  // decode-side state
  typedef logic [`CC_WIDTH-1:0]      condCodeT; // n z p
  typedef logic [`NUM_REGS-1:0]      regMaskT;  // one bit per register

endpackage

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module instrDecoder
(
  input  decodePkg::instrT    instr,

  output decodePkg::opcodeT   opcode,
  output decodePkg::regIdxT   src1Idx,
  output decodePkg::regIdxT   src2Idx,
  output decodePkg::regIdxT   destIdx,
  output logic                useSrc1,
  output logic                useSrc2,
  output logic                writesDest,
  output logic                isBranch,
  output decodePkg::condCodeT branchMask,
  output logic                isLink,
  output decodePkg::regDataT  imm
);

  ////////////////////////////////////////
  // fixed fields
  ////////////////////////////////////////
  assign opcode     = instr[31:24];
  assign branchMask = instr[26:24];  // n z p bits of a BR

  // prefix match plus a nonzero mask
  assign isBranch = (opcode[7:3] == `OP_BR_PREFIX) && (opcode[2:0] != 3'b000);

  // sign extend low half into a register word
  assign imm = decodePkg::regDataT'($signed(instr[15:0]));

  ////////////////////////////////////////
  // per-class register selection
  ////////////////////////////////////////
  always_comb
  begin
    // usual spots, nothing used yet
    src1Idx    = instr[19:16];
    src2Idx    = instr[11:8];
    destIdx    = '0;
    useSrc1    = 1'b0;
    useSrc2    = 1'b0;
    writesDest = 1'b0;
    isLink     = 1'b0;

    case (opcode)
      `OP_ADD, `OP_AND:
      begin
        useSrc1    = 1'b1;
        useSrc2    = 1'b1;
        writesDest = 1'b1;
        destIdx    = instr[23:20];
      end
      `OP_ADDI, `OP_ANDI, `OP_LDW:
      begin
        useSrc1    = 1'b1;          // base or first operand
        writesDest = 1'b1;
        destIdx    = instr[23:20];
      end
      `OP_MOV:
      begin
        useSrc2    = 1'b1;          // source sits in 11:8
        writesDest = 1'b1;
        destIdx    = instr[19:16];  // dest moves down for moves
      end
      `OP_MOVI:
      begin
        writesDest = 1'b1;
        destIdx    = instr[19:16];
      end
      `OP_STW:
      begin
        src2Idx = instr[23:20];     // store value rides the second port
        useSrc1 = 1'b1;             // base
        useSrc2 = 1'b1;
      end
      `OP_JMP:
      begin
        useSrc1 = 1'b1;             // target register
      end
      `OP_JSR:
      begin
        writesDest = 1'b1;
        destIdx    = decodePkg::regIdxT'(`LINK_REG);
        isLink     = 1'b1;
      end
      `OP_JSRR:
      begin
        useSrc1    = 1'b1;          // target register
        writesDest = 1'b1;
        destIdx    = decodePkg::regIdxT'(`LINK_REG);
        isLink     = 1'b1;
      end
      default:
      begin
        // branches and unknown opcodes read and write nothing
      end
    endcase
  end

endmodule

/* rtl/issueStage.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module issueStage
(
  input  logic                I_CLOCK,
  input  logic                rstN,

  // fetch side
  input  logic                inValid,
  input  decodePkg::pcT       inPc,
  output logic                inReady,

  // from instrDecoder
  input  decodePkg::opcodeT   opcode,
  input  decodePkg::regIdxT   src1Idx,
  input  decodePkg::regIdxT   src2Idx,
  input  decodePkg::regIdxT   destIdx,
  input  logic                useSrc1,
  input  logic                useSrc2,
  input  logic                writesDest,
  input  logic                isBranch,
  input  decodePkg::condCodeT branchMask,
  input  logic                isLink,
  input  decodePkg::regDataT  imm,

  // from regFileScoreboard
  input  decodePkg::regDataT  src1Data,
  input  decodePkg::regDataT  src2Data,
  input  logic                src1Ready,
  input  logic                src2Ready,
  input  logic                allReady,
  input  decodePkg::condCodeT condCode,

  output logic                claimEnable,
  output decodePkg::regIdxT   claimIdx,

  // execute side
  output logic                outValid,
  input  logic                outReady,
  output decodePkg::pcT       outPc,
  output decodePkg::opcodeT   outOpcode,
  output decodePkg::regDataT  outSrc1,
  output decodePkg::regDataT  outSrc2,
  output decodePkg::regDataT  outImm,
  output decodePkg::regIdxT   outDestIdx,
  output logic                outWritesDest,
  output decodePkg::regDataT  outDestValue
);

  logic               hazard;
  logic               accept;
  logic               branchTaken;
  logic               isStore;
  logic               isJump;
  logic               isJsr;
  decodePkg::regDataT shiftedImm;
  decodePkg::regDataT immNext;
  decodePkg::regDataT destValueNext;

  ////////////////////////////////////////
  // hazard and handshake
  ////////////////////////////////////////
  assign hazard = (useSrc1 && !src1Ready)
               || (useSrc2 && !src2Ready)
               || (isBranch && !allReady);               // branch waits for everything

  assign inReady = !hazard && (!outValid || outReady);  // room or draining
  assign accept  = inValid && inReady;

  // dest goes busy on the accept edge
  assign claimEnable = accept && writesDest;
  assign claimIdx    = destIdx;

  ////////////////////////////////////////
  // payload select
  ////////////////////////////////////////
  assign isStore     = (opcode == `OP_STW);
  assign isJump      = (opcode == `OP_JMP);
  assign isJsr       = (opcode == `OP_JSR);
  assign shiftedImm  = imm << 2;                          // word offset to bytes
  assign branchTaken = isBranch && ((condCode & branchMask) != '0);

  always_comb
  begin
    immNext = imm;
    if (isBranch)
      immNext = branchTaken ? shiftedImm : '0;  // zero offset = fall through
    else if (isJsr)
      immNext = shiftedImm;

    destValueNext = '0;
    if (isStore)
      destValueNext = src2Data;                 // store value
    else if (isJump)
      destValueNext = src1Data;                 // target address
    else if (isLink)
      destValueNext = decodePkg::regDataT'(inPc);  // return address
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////
  always_ff @(posedge I_CLOCK)
  begin
    if (!rstN)
      outValid <= 1'b0;
    else if (accept)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0;  // drained, nothing new
  end

  // holds whenever no accept, covers back-pressure
  always_ff @(posedge I_CLOCK)
  begin
    if (accept)
    begin
      outPc         <= inPc;
      outOpcode     <= opcode;
      outSrc1       <= useSrc1 ? src1Data : '0;
      outSrc2       <= (useSrc2 && !isStore) ? src2Data : '0;
      outImm        <= immNext;
      outDestIdx    <= destIdx;
      outWritesDest <= writesDest;
      outDestValue  <= destValueNext;
    end
  end

endmodule

/* rtl/regFileScoreboard.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module regFileScoreboard
(
  input  logic                I_CLOCK,
  input  logic                rstN,

  // writeback
  input  logic                wbEnable,
  input  decodePkg::regIdxT   wbIdx,
  input  decodePkg::regDataT  wbData,

  // read ports
  input  decodePkg::regIdxT   src1Idx,
  input  decodePkg::regIdxT   src2Idx,

  // dest claim from issue
  input  logic                claimEnable,
  input  decodePkg::regIdxT   claimIdx,

  output decodePkg::regDataT  src1Data,
  output decodePkg::regDataT  src2Data,
  output logic                src1Ready,
  output logic                src2Ready,
  output logic                allReady,
  output decodePkg::condCodeT condCode
);

  ////////////////////////////////////////
  // state
  ////////////////////////////////////////
  decodePkg::regDataT  regs [`NUM_REGS];
  decodePkg::regMaskT  validBits;    // 1 = value is current
  decodePkg::condCodeT ccReg;

  decodePkg::regMaskT  wbMask;
  decodePkg::regMaskT  claimMask;
  decodePkg::regMaskT  validWithWb;  // scoreboard as seen this cycle
  decodePkg::condCodeT wbCc;

  // one-hot masks for the two scoreboard updates
  assign wbMask    = wbEnable ? (decodePkg::regMaskT'(1) << wbIdx) : '0;
  assign claimMask = claimEnable ? (decodePkg::regMaskT'(1) << claimIdx) : '0;

  assign validWithWb = validBits | wbMask;  // same-cycle writeback counts

  // code from the signed writeback value
  always_comb
  begin
    if ($signed(wbData) < 0)
      wbCc = `CC_N;
    else if (wbData == '0)
      wbCc = `CC_Z;
    else
      wbCc = `CC_P;
  end

  ////////////////////////////////////////
  // reads with writeback bypass
  ////////////////////////////////////////
  assign src1Data = (wbEnable && (wbIdx == src1Idx)) ? wbData : regs[src1Idx];
  assign src2Data = (wbEnable && (wbIdx == src2Idx)) ? wbData : regs[src2Idx];

  assign src1Ready = validWithWb[src1Idx];
  assign src2Ready = validWithWb[src2Idx];
  assign allReady  = &validWithWb;         // branch gate

  // a branch in the writeback cycle sees the new code
  assign condCode = wbEnable ? wbCc : ccReg;

  ////////////////////////////////////////
  // writes
  ////////////////////////////////////////
  always_ff @(posedge I_CLOCK)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
      validBits <= '1;   // nothing in flight
      ccReg     <= '0;   // no branch taken until first writeback
    end
    else
    begin
      if (wbEnable)
      begin
        regs[wbIdx] <= wbData;
        ccReg       <= wbCc;
      end
      // claim applied after the set, so it wins on a tie
      validBits <= validWithWb & ~claimMask;
    end
  end

endmodule

/* sim.f */
+incdir+include
rtl/decode_pkg.sv
rtl/instrDecoder.sv
rtl/regFileScoreboard.sv
rtl/issueStage.sv
rtl/decodeStage.sv
dv/tbClockGen.sv
dv/decodeStage_asserts.sv
dv/decodeStage_tb.sv
